//--- build.f
verilog/acq_cfg_pkg.sv
verilog/acq_ctrl_pkg.sv
verilog/acq_arm_sync.sv
verilog/acq_sequencer.sv
verilog/acq_strobe_gen.sv
verilog/adc_acq_ctrl.sv
sim/adc_acq_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module adc_acq_ctrl_tb -o sim_adc_acq_ctrl

./obj_dir/sim_adc_acq_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- sim/adc_acq_ctrl_tb.sv
`timescale 1ns/1ps

module adc_acq_ctrl_tb import acq_cfg_pkg::*, acq_ctrl_pkg::*;;

    localparam int sync_stages = default_enable_sync_stages;
    localparam int done_stages = default_done_sync_stages;
    localparam int num_rows    = 4;

    // one fill per row
    typedef struct packed {
        logic [1:0] enables;
        logic [7:0] bursts;
        logic       dummy;
        fill_type_t exp_fill_type;
    } row_t;

    logic          clk = 1'b0;
    logic          adc_acq_full_reset = 1'b1;
    logic          acq_enable0 = 1'b0;
    logic          acq_enable1 = 1'b0;
    logic          acq_trig = 1'b0;
    logic          trig_fifo_empty = 1'b1;
    logic          burst_cntr_zero;
    logic          ddr3_wr_done = 1'b0;
    logic          dummy_dat_reset_mode = 1'b0;
    fill_type_t    fill_type;
    mux_sel_t      mux_sel;
    cntr_ctl_t     cntr_ctl;
    circ_buf_ctl_t circ_buf_ctl;
    logic          dummy_dat_reset;
    logic          adc_mux_checksum_update;
    logic          adc_acq_out_valid;
    logic          trig_pulse;
    logic          acq_enabled;
    logic          acq_done;
    logic          sm_idle;

    // burst counter and trigger FIFO models
    logic [7:0] burst_cnt = 8'd0;
    logic [7:0] burst_load = 8'd0;
    logic       fifo_load = 1'b0;
    logic       fifo_flush = 1'b0;
    logic [7:0] lfsr = 8'd90;
    int         cyc = 0;
    row_t       rows [num_rows];

    // strobe counters, never cleared, the stimulus takes differences
    int n_valid = 0;
    int n_cks_upd = 0;
    int n_addr_en = 0;
    int n_latch = 0;
    int n_inc_rd = 0;
    int n_dat_sel = 0;
    int n_fill_hdr = 0;
    int n_wfm_hdr = 0;
    int n_cks_sel = 0;
    int n_burst_init = 0;
    int n_init_rd = 0;
    int n_trig_rd = 0;
    int n_fill_cntr = 0;
    int n_dummy = 0;
    int n_pulse = 0;

    adc_acq_ctrl #(
        .enable_sync_stages (sync_stages),
        .done_sync_stages   (done_stages)
    ) adc_acq_ctrl_inst (
        .clk                     (clk),
        .adc_acq_full_reset      (adc_acq_full_reset),
        .acq_enable0             (acq_enable0),
        .acq_enable1             (acq_enable1),
        .acq_trig                (acq_trig),
        .trig_fifo_empty         (trig_fifo_empty),
        .burst_cntr_zero         (burst_cntr_zero),
        .ddr3_wr_done            (ddr3_wr_done),
        .dummy_dat_reset_mode    (dummy_dat_reset_mode),
        .fill_type               (fill_type),
        .mux_sel                 (mux_sel),
        .cntr_ctl                (cntr_ctl),
        .circ_buf_ctl            (circ_buf_ctl),
        .dummy_dat_reset         (dummy_dat_reset),
        .adc_mux_checksum_update (adc_mux_checksum_update),
        .adc_acq_out_valid       (adc_acq_out_valid),
        .trig_pulse              (trig_pulse),
        .acq_enabled             (acq_enabled),
        .acq_done                (acq_done),
        .sm_idle                 (sm_idle)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        // counter loads on init, counts down once per burst
        if (cntr_ctl.burst_cntr_init) begin
            burst_cnt <= burst_load;
        end else if (cntr_ctl.burst_cntr_en) begin
            burst_cnt <= burst_cnt - 8'd1;
        end
        // one-entry FWFT FIFO, pop wins over a load
        if (adc_acq_full_reset || fifo_flush || circ_buf_ctl.trig_addr_rd_en) begin
            trig_fifo_empty <= 1'b1;
        end else if (fifo_load) begin
            trig_fifo_empty <= 1'b0;
        end
    end

    assign burst_cntr_zero = (burst_cnt == 8'd0);

    // registered outputs are stable at the falling edge
    always @(negedge clk) begin
        n_valid      <= n_valid + int'(adc_acq_out_valid);
        n_cks_upd    <= n_cks_upd + int'(adc_mux_checksum_update);
        n_addr_en    <= n_addr_en + int'(cntr_ctl.address_cntr_en);
        n_latch      <= n_latch + int'(circ_buf_ctl.latch_dat);
        n_inc_rd     <= n_inc_rd + int'(circ_buf_ctl.inc_rd_addr);
        n_dat_sel    <= n_dat_sel + int'(mux_sel.dat_sel);
        n_fill_hdr   <= n_fill_hdr + int'(mux_sel.fill_hdr_sel);
        n_wfm_hdr    <= n_wfm_hdr + int'(mux_sel.wfm_hdr_sel);
        n_cks_sel    <= n_cks_sel + int'(mux_sel.checksum_sel);
        n_burst_init <= n_burst_init + int'(cntr_ctl.burst_cntr_init);
        n_init_rd    <= n_init_rd + int'(circ_buf_ctl.init_rd_addr);
        n_trig_rd    <= n_trig_rd + int'(circ_buf_ctl.trig_addr_rd_en);
        n_fill_cntr  <= n_fill_cntr + int'(cntr_ctl.fill_cntr_en);
        n_dummy      <= n_dummy + int'(dummy_dat_reset);
        n_pulse      <= n_pulse + int'(trig_pulse);
    end

    // galois form, taps 8,6,5,4
    function automatic logic [7:0] lfsr_next(logic [7:0] s);
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    task automatic report_mismatch(string what, int got, int exp);
        $display("FAIL t=%0t %s: got %0h, expected %0h", $time, what, got, exp);
        $display("Done: errors found");
        $fatal(1, "mismatch in %s", what);
    endtask

    task automatic report_timeout(string what);
        $display("timed out while waiting for %s", what);
        $display("Done: errors found");
        $fatal(1, "timeout");
    endtask

    task automatic check_fill_type(fill_type_t got, fill_type_t exp, string what);
        if (got !== exp) begin
            report_mismatch(what, int'(got), int'(exp));
        end
    endtask

    task automatic check_mux_sel(mux_sel_t got, mux_sel_t exp, string what);
        if (got !== exp) begin
            report_mismatch(what, int'(got), int'(exp));
        end
    endtask

    task automatic check_cntr_ctl(cntr_ctl_t got, cntr_ctl_t exp, string what);
        if (got !== exp) begin
            report_mismatch(what, int'(got), int'(exp));
        end
    endtask

    task automatic check_circ_buf(circ_buf_ctl_t got, circ_buf_ctl_t exp, string what);
        if (got !== exp) begin
            report_mismatch(what, int'(got), int'(exp));
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            report_mismatch(what, int'(got), int'(exp));
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        if (got != exp) begin
            report_mismatch(what, got, exp);
        end
    endtask

    // inputs change a little after the rising edge
    task automatic drive_slot();
        @(posedge clk);
        #1;
    endtask

    // ddr3 write delay, one lfsr step per bit
    task automatic lfsr_delay(output int d);
        d = 2;
        for (int b = 0; b < 4; b++) begin
            lfsr = lfsr_next(lfsr);
            d = d + (int'(lfsr[0]) << b);
        end
    endtask

    initial begin
        int base [15];
        int t0;
        int n;
        int d;
        int k;

        rows[0] = '{enables: 2'b01, bursts: 8'd1, dummy: 1'b0, exp_fill_type: 2'b01};
        rows[1] = '{enables: 2'b10, bursts: 8'd3, dummy: 1'b1, exp_fill_type: 2'b10};
        rows[2] = '{enables: 2'b11, bursts: 8'd2, dummy: 1'b1, exp_fill_type: 2'b11};
        rows[3] = '{enables: 2'b01, bursts: 8'd5, dummy: 1'b0, exp_fill_type: 2'b01};

        repeat (2) @(posedge clk);
        #1;
        adc_acq_full_reset = 1'b0;
        @(negedge clk);
        check_mux_sel(mux_sel, '0, "mux_sel after reset");
        check_cntr_ctl(cntr_ctl, '0, "cntr_ctl after reset");
        check_circ_buf(circ_buf_ctl, '0, "circ_buf_ctl after reset");
        check_bit(adc_acq_out_valid, 1'b0, "out_valid after reset");
        check_bit(acq_done, 1'b0, "acq_done after reset");
        check_bit(trig_pulse, 1'b0, "trig_pulse after reset");
        check_bit(acq_enabled, 1'b0, "acq_enabled after reset");
        check_bit(sm_idle, 1'b1, "sm_idle after reset");

        // not armed: a trigger with an address waiting does nothing
        drive_slot();
        acq_trig  = 1'b1;
        fifo_load = 1'b1;
        repeat (sync_stages + 6) begin
            @(negedge clk);
            check_bit(acq_enabled, 1'b0, "acq_enabled while disarmed");
            check_bit(trig_pulse, 1'b0, "trig_pulse while disarmed");
        end
        drive_slot();
        acq_trig   = 1'b0;
        fifo_load  = 1'b0;
        fifo_flush = 1'b1;
        drive_slot();
        fifo_flush = 1'b0;
        repeat (sync_stages + 2) drive_slot();

        for (int r = 0; r < num_rows; r++) begin
            drive_slot();
            acq_enable1          = rows[r].enables[1];
            acq_enable0          = rows[r].enables[0];
            dummy_dat_reset_mode = rows[r].dummy;
            burst_load           = rows[r].bursts;
            repeat (sync_stages + 2) @(negedge clk);
            check_fill_type(fill_type, rows[r].exp_fill_type, "fill_type");
            base = '{n_valid, n_cks_upd, n_addr_en, n_latch, n_inc_rd, n_dat_sel,
                     n_fill_hdr, n_wfm_hdr, n_cks_sel, n_burst_init, n_init_rd,
                     n_trig_rd, n_fill_cntr, n_dummy, n_pulse};

            // trigger edge and address arrive together
            drive_slot();
            acq_trig  = 1'b1;
            fifo_load = 1'b1;
            t0 = cyc;
            drive_slot();
            fifo_load = 1'b0;
            k = 0;
            while (trig_pulse !== 1'b1) begin
                @(negedge clk);
                k++;
                if (k > 50) begin
                    report_timeout("trig_pulse");
                end
            end
            check_count(cyc - t0, sync_stages + 1, "trig_pulse latency");

            // fill runs until the checksum word is counted
            k = 0;
            while (cntr_ctl.fill_cntr_en !== 1'b1) begin
                @(negedge clk);
                k++;
                if (k > 200) begin
                    report_timeout("end of fill");
                end
            end
            lfsr_delay(d);
            repeat (d) begin
                @(negedge clk);
                check_bit(acq_done, 1'b0, "acq_done before ddr3_wr_done");
            end
            drive_slot();
            ddr3_wr_done = 1'b1;
            k = 0;
            while (acq_done !== 1'b1) begin
                @(negedge clk);
                k++;
                if (k > 20) begin
                    report_timeout("acq_done");
                end
            end
            // trigger still high holds done
            repeat (6) begin
                @(negedge clk);
                check_bit(acq_done, 1'b1, "acq_done while trigger held");
                check_bit(sm_idle, 1'b0, "sm_idle while trigger held");
                check_bit(acq_enabled, 1'b1, "acq_enabled while in done");
            end
            drive_slot();
            acq_trig     = 1'b0;
            ddr3_wr_done = 1'b0;
            k = 0;
            while (sm_idle !== 1'b1) begin
                @(negedge clk);
                k++;
                if (k > 20) begin
                    report_timeout("sm_idle after trigger release");
                end
            end
            check_bit(acq_done, 1'b0, "acq_done after release");
            check_bit(acq_enabled, 1'b0, "acq_enabled after release");
            repeat (sync_stages + 2) @(negedge clk);

            n = int'(rows[r].bursts);
            check_count(n_valid - base[0], n + 3, "out_valid count");
            check_count(n_cks_upd - base[1], n, "checksum_update count");
            check_count(n_addr_en - base[2], n + 3, "address_cntr_en count");
            check_count(n_latch - base[3], 4 * n + 2, "latch_dat count");
            check_count(n_inc_rd - base[4], 4 * n + 1, "inc_rd_addr count");
            check_count(n_dat_sel - base[5], 4 * n + 2, "dat_sel count");
            check_count(n_fill_hdr - base[6], 1, "fill_hdr_sel count");
            check_count(n_wfm_hdr - base[7], 1, "wfm_hdr_sel count");
            check_count(n_cks_sel - base[8], 1, "checksum_sel count");
            check_count(n_burst_init - base[9], 1, "burst_cntr_init count");
            check_count(n_init_rd - base[10], 1, "init_rd_addr count");
            check_count(n_trig_rd - base[11], 1, "trig_addr_rd_en count");
            check_count(n_fill_cntr - base[12], 1, "fill_cntr_en count");
            check_count(n_dummy - base[13], int'(rows[r].dummy), "dummy_dat_reset count");
            check_count(n_pulse - base[14], 1, "trig_pulse count");
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- verilog/acq_arm_sync.sv
`timescale 1ns/1ps

module acq_arm_sync import acq_cfg_pkg::*; #(
    parameter int enable_sync_stages = default_enable_sync_stages,
    parameter int done_sync_stages   = default_done_sync_stages
) (
    input  logic       clk,
    input  logic       adc_acq_full_reset,
    input  logic       acq_enable0,
    input  logic       acq_enable1,
    input  logic       acq_trig,
    input  logic       ddr3_wr_done,
    output logic       mode_enabled,
    output fill_type_t fill_type,
    output logic       trig_level,
    output logic       trig_pulse,
    output logic       wr_done
);

    // the three front-panel inputs share one synchronizer chain
    typedef struct packed {
        logic trig;
        logic enable1;
        logic enable0;
    } sync_in_t;

    sync_in_t                          raw_in;
    sync_in_t [enable_sync_stages-1:0] in_sync;
    sync_in_t                          in_last;
    // one stage past the end of the chain, for edge detection
    logic                              trig_dly;
    logic [done_sync_stages-1:0]       done_sync;

    assign raw_in  = {acq_trig, acq_enable1, acq_enable0};
    assign in_last = in_sync[enable_sync_stages-1];

    // stage 0 samples the pins, the last stage is the one used
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            in_sync   <= '0;
            trig_dly  <= 1'b0;
            done_sync <= '0;
        end else begin
            in_sync   <= {in_sync[enable_sync_stages-2:0], raw_in};
            trig_dly  <= in_last.trig;
            done_sync <= {done_sync[done_sync_stages-2:0], ddr3_wr_done};
        end
    end

    // armed whenever either enable is set
    // fill type is the raw enable pair, registered alongside
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            mode_enabled <= 1'b0;
            fill_type    <= '0;
            trig_pulse   <= 1'b0;
        end else begin
            mode_enabled <= in_last.enable0 | in_last.enable1;
            fill_type    <= {in_last.enable1, in_last.enable0};
            // rising edge at the end of the chain, only while armed
            trig_pulse   <= in_last.trig & ~trig_dly & mode_enabled;
        end
    end

    // level of the trigger, used by the sequencer to hold in done
    assign trig_level = in_last.trig;

    // write-done level in the clk domain
    assign wr_done = done_sync[done_sync_stages-1];

endmodule

//--- verilog/acq_cfg_pkg.sv
package acq_cfg_pkg;

    // fill type as seen by the burst-size logic downstream
    // bit 1 comes from acq_enable1, bit 0 from acq_enable0
    // 2'b00 means the channel is not armed
    typedef logic [1:0] fill_type_t;

    // depth of the enable and trigger synchronizers
    // the trigger pulse and the arming both lag the pins by this many
    // cycles plus one output register
    localparam int default_enable_sync_stages = 4;

    // depth of the ddr3_wr_done synchronizer
    // the write controller runs on its own clock, two flops are enough
    // since the signal is a slow level
    localparam int default_done_sync_stages = 2;

endpackage

//--- verilog/acq_ctrl_pkg.sv
package acq_ctrl_pkg;

    // fill sequencer states, in the order they are visited
    typedef enum logic [4:0] {
        // waiting for either enable
        idle,
        // armed, waiting for a trigger address in the FIFO
        watch_for_trig,
        // fill header, once per trigger
        fill_init1,
        fill_init2,
        // waveform header and circular-buffer read setup
        wfm_init1,
        wfm_init2,
        wfm_init3,
        // one four-word ADC burst per pass
        run1,
        run2,
        run3,
        run4,
        // flush the last words out of the buffer read path
        wfm_tst1,
        wfm_tst2,
        // checksum word
        checksum1,
        checksum2,
        // waiting for the DDR3 write controller
        ddr3_wait,
        // held until the trigger drops
        done
    } acq_state_t;

    // output mux selects, at most one is high in any cycle
    typedef struct packed {
        logic fill_hdr_sel;
        logic wfm_hdr_sel;
        logic dat_sel;
        logic checksum_sel;
    } mux_sel_t;

    // enables for the address, burst and fill counters
    typedef struct packed {
        logic address_cntr_en;
        logic burst_cntr_init;
        logic burst_cntr_en;
        logic fill_cntr_en;
    } cntr_ctl_t;

    // circular-buffer read side and trigger FIFO pop
    typedef struct packed {
        logic init_rd_addr;
        logic inc_rd_addr;
        logic latch_dat;
        logic trig_addr_rd_en;
    } circ_buf_ctl_t;

endpackage

//--- verilog/acq_sequencer.sv
`timescale 1ns/1ps

module acq_sequencer import acq_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       adc_acq_full_reset,
    input  logic       mode_enabled,
    input  logic       trig_level,
    input  logic       trig_fifo_empty,
    input  logic       burst_cntr_zero,
    input  logic       wr_done,
    output acq_state_t next_state
);

    acq_state_t state;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // next_state also feeds the strobe decoder, so strobes line up
    // with state entry
    always_comb begin
        next_state = state;
        case (state)
            // stay here until one of the enables is set
            idle: begin
                if (mode_enabled) begin
                    next_state = watch_for_trig;
                end
            end
            // the trigger FIFO is FWFT, non-empty means an address is ready
            // DDR3 reads may run while we sit here
            watch_for_trig: begin
                if (!trig_fifo_empty) begin
                    next_state = fill_init1;
                end
            end
            // two cycles for the fill header
            fill_init1: next_state = fill_init2;
            fill_init2: next_state = wfm_init1;
            // three cycles for the waveform header and read setup
            wfm_init1:  next_state = wfm_init2;
            wfm_init2:  next_state = wfm_init3;
            wfm_init3:  next_state = run1;
            // one 32-bit word per run state, forwarded as 128 bits in run4
            run1:       next_state = run2;
            run2:       next_state = run3;
            run3:       next_state = run4;
            run4: begin
                // counter was decremented on entry to run1
                if (burst_cntr_zero) begin
                    next_state = wfm_tst1;
                end else begin
                    next_state = run1;
                end
            end
            // buffer read latency, the last words are still in flight
            wfm_tst1:   next_state = wfm_tst2;
            wfm_tst2:   next_state = checksum1;
            checksum1:  next_state = checksum2;
            checksum2:  next_state = ddr3_wait;
            // hold until the write controller has drained the fill
            ddr3_wait: begin
                if (wr_done) begin
                    next_state = done;
                end
            end
            // a trigger still held high must not start another fill
            done: begin
                if (!(mode_enabled && trig_level)) begin
                    next_state = idle;
                end
            end
            default:    next_state = idle;
        endcase
    end

endmodule

//--- verilog/acq_strobe_gen.sv
`timescale 1ns/1ps

module acq_strobe_gen import acq_ctrl_pkg::*; (
    input  logic          clk,
    input  logic          adc_acq_full_reset,
    input  acq_state_t    next_state,
    input  logic          dummy_dat_reset_mode,
    output mux_sel_t      mux_sel,
    output cntr_ctl_t     cntr_ctl,
    output circ_buf_ctl_t circ_buf_ctl,
    output logic          dummy_dat_reset,
    output logic          adc_mux_checksum_update,
    output logic          adc_acq_out_valid,
    output logic          acq_enabled,
    output logic          acq_done,
    output logic          sm_idle
);

    // header and checksum words are valid one cycle after entry
    logic immed_valid;
    // burst words need the extra buffer read delay
    logic burst_start;
    logic burst_dly0;
    logic burst_dly1;

    // every strobe is registered from next_state, so it is high in
    // the same cycles the sequencer spends in the state
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            mux_sel         <= '0;
            cntr_ctl        <= '0;
            circ_buf_ctl    <= '0;
            dummy_dat_reset <= 1'b0;
            immed_valid     <= 1'b0;
            burst_start     <= 1'b0;
            acq_enabled     <= 1'b0;
            acq_done        <= 1'b0;
            sm_idle         <= 1'b1;
        end else begin
            mux_sel         <= '0;
            cntr_ctl        <= '0;
            circ_buf_ctl    <= '0;
            dummy_dat_reset <= 1'b0;
            immed_valid     <= 1'b0;
            burst_start     <= 1'b0;
            acq_done        <= 1'b0;
            sm_idle         <= 1'b0;
            // low only while DDR3 is free for reads
            acq_enabled     <= 1'b1;
            case (next_state)
                idle, watch_for_trig: begin
                    sm_idle     <= 1'b1;
                    acq_enabled <= 1'b0;
                end
                fill_init1: begin
                    mux_sel.fill_hdr_sel <= 1'b1;
                end
                fill_init2: begin
                    // fill header goes to the FIFO
                    immed_valid              <= 1'b1;
                    cntr_ctl.address_cntr_en <= 1'b1;
                end
                wfm_init1: begin
                    // 0 lets the dummy data free-run, 1 restarts it per waveform
                    dummy_dat_reset              <= dummy_dat_reset_mode;
                    circ_buf_ctl.init_rd_addr    <= 1'b1;
                    // pop the trigger address, FWFT so it was already on the bus
                    circ_buf_ctl.trig_addr_rd_en <= 1'b1;
                end
                wfm_init2: begin
                    immed_valid              <= 1'b1;
                    cntr_ctl.burst_cntr_init <= 1'b1;
                    mux_sel.wfm_hdr_sel      <= 1'b1;
                end
                wfm_init3: begin
                    // start the read, data is not ready to latch yet
                    cntr_ctl.address_cntr_en <= 1'b1;
                    circ_buf_ctl.inc_rd_addr <= 1'b1;
                end
                run1, run2, run3, run4: begin
                    circ_buf_ctl.latch_dat   <= 1'b1;
                    circ_buf_ctl.inc_rd_addr <= 1'b1;
                    mux_sel.dat_sel          <= 1'b1;
                    // one decrement per burst
                    cntr_ctl.burst_cntr_en   <= (next_state == run1);
                    // burst is complete in run4
                    cntr_ctl.address_cntr_en <= (next_state == run4);
                    burst_start              <= (next_state == run4);
                end
                wfm_tst1, wfm_tst2: begin
                    // last words of the final burst
                    circ_buf_ctl.latch_dat <= 1'b1;
                    mux_sel.dat_sel        <= 1'b1;
                end
                checksum1: begin
                    mux_sel.checksum_sel <= 1'b1;
                end
                checksum2: begin
                    immed_valid              <= 1'b1;
                    cntr_ctl.address_cntr_en <= 1'b1;
                    cntr_ctl.fill_cntr_en    <= 1'b1;
                end
                done: begin
                    acq_done <= 1'b1;
                end
                default: begin
                    // ddr3_wait drives nothing beyond acq_enabled
                end
            endcase
        end
    end

    // burst path: checksum update two cycles after run4 entry,
    // valid one cycle later once the 128-bit word has settled
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            burst_dly0              <= 1'b0;
            burst_dly1              <= 1'b0;
            adc_mux_checksum_update <= 1'b0;
            adc_acq_out_valid       <= 1'b0;
        end else begin
            burst_dly0              <= burst_start;
            burst_dly1              <= burst_dly0;
            adc_mux_checksum_update <= burst_dly0;
            adc_acq_out_valid       <= immed_valid | burst_dly1;
        end
    end

endmodule

//--- verilog/adc_acq_ctrl.sv
`timescale 1ns/1ps

module adc_acq_ctrl import acq_cfg_pkg::*, acq_ctrl_pkg::*; #(
    parameter int enable_sync_stages = default_enable_sync_stages,
    parameter int done_sync_stages   = default_done_sync_stages
) (
    input  logic          clk,
    input  logic          adc_acq_full_reset,
    input  logic          acq_enable0,
    input  logic          acq_enable1,
    input  logic          acq_trig,
    input  logic          trig_fifo_empty,
    input  logic          burst_cntr_zero,
    input  logic          ddr3_wr_done,
    input  logic          dummy_dat_reset_mode,
    output fill_type_t    fill_type,
    output mux_sel_t      mux_sel,
    output cntr_ctl_t     cntr_ctl,
    output circ_buf_ctl_t circ_buf_ctl,
    output logic          dummy_dat_reset,
    output logic          adc_mux_checksum_update,
    output logic          adc_acq_out_valid,
    output logic          trig_pulse,
    output logic          acq_enabled,
    output logic          acq_done,
    output logic          sm_idle
);

    // arming and synchronized levels
    logic       mode_enabled;
    logic       trig_level;
    logic       wr_done;
    // sequencer to decoder
    acq_state_t next_state;

    // pins into the clk domain, arming and trigger edge
    acq_arm_sync #(
        .enable_sync_stages (enable_sync_stages),
        .done_sync_stages   (done_sync_stages)
    ) acq_arm_sync_inst (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .acq_enable0        (acq_enable0),
        .acq_enable1        (acq_enable1),
        .acq_trig           (acq_trig),
        .ddr3_wr_done       (ddr3_wr_done),
        .mode_enabled       (mode_enabled),
        .fill_type          (fill_type),
        .trig_level         (trig_level),
        .trig_pulse         (trig_pulse),
        .wr_done            (wr_done)
    );

    // fill sequence FSM
    acq_sequencer acq_sequencer_inst (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .mode_enabled       (mode_enabled),
        .trig_level         (trig_level),
        .trig_fifo_empty    (trig_fifo_empty),
        .burst_cntr_zero    (burst_cntr_zero),
        .wr_done            (wr_done),
        .next_state         (next_state)
    );

    // registered datapath strobes
    acq_strobe_gen acq_strobe_gen_inst (
        .clk                     (clk),
        .adc_acq_full_reset      (adc_acq_full_reset),
        .next_state              (next_state),
        .dummy_dat_reset_mode    (dummy_dat_reset_mode),
        .mux_sel                 (mux_sel),
        .cntr_ctl                (cntr_ctl),
        .circ_buf_ctl            (circ_buf_ctl),
        .dummy_dat_reset         (dummy_dat_reset),
        .adc_mux_checksum_update (adc_mux_checksum_update),
        .adc_acq_out_valid       (adc_acq_out_valid),
        .acq_enabled             (acq_enabled),
        .acq_done                (acq_done),
        .sm_idle                 (sm_idle)
    );

endmodule
